//--- design/bist_reg_pkg.sv
`default_nettype none

package bist_reg_pkg;

  // ----------------------------------------------------------
  // Register port geometry
  // ----------------------------------------------------------
  localparam int CTRL_ADDR_W = 20;
  localparam int CTRL_DATA_W = 32;

  // Byte addresses, one 32-bit word each
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_CTRL             = 20'h00;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_CLK_RATE         = 20'h04;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_NUM_BYTES_LO     = 20'h08;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_NUM_BYTES_HI     = 20'h0C;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_TX_BYTE_COUNT_LO = 20'h10;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_TX_BYTE_COUNT_HI = 20'h14;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_RX_BYTE_COUNT_LO = 20'h18;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_RX_BYTE_COUNT_HI = 20'h1C;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_ERROR_COUNT_LO   = 20'h20;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_ERROR_COUNT_HI   = 20'h24;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_CYCLE_COUNT_LO   = 20'h28;
  localparam logic [CTRL_ADDR_W-1:0] REG_BIST_CYCLE_COUNT_HI   = 20'h2C;

  // CTRL register bit positions
  localparam int REG_BIST_START_POS   = 0;
  localparam int REG_BIST_STOP_POS    = 1;
  localparam int REG_BIST_CLEAR_POS   = 2;
  localparam int REG_BIST_CONT_POS    = 3;
  localparam int REG_BIST_RUNNING_POS = 4;
  localparam int REG_BIST_INJECT_POS  = 5;

  // Frequency of clk in Hz
  localparam logic [CTRL_DATA_W-1:0] CLK_RATE = 32'd10_000_000;

  // ----------------------------------------------------------
  // Port and command bundles
  // ----------------------------------------------------------
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [CTRL_ADDR_W-1:0] addr;
    logic [CTRL_DATA_W-1:0] data;
  } ctrl_req_t;

  typedef struct packed {
    logic                   ack;
    logic [CTRL_DATA_W-1:0] data;
  } ctrl_resp_t;

  // Pulses except continuous, which is a level
  typedef struct packed {
    logic start;
    logic stop;
    logic clear;
    logic inject;
    logic continuous;
  } bist_cmd_t;

endpackage

`default_nettype wire

//--- design/bist_data_pkg.sv
`default_nettype none

package bist_data_pkg;

  // ----------------------------------------------------------
  // Data path sizing
  // ----------------------------------------------------------
  // Power of two, or the byte conversion breaks
  localparam int DATA_W     = 32;
  localparam int BYTE_SHIFT = $clog2(DATA_W / 8);
  // Wider than 32 so the high halves carry something
  localparam int COUNT_W    = 40;
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Galois LFSR polynomial and start value
  localparam logic [DATA_W-1:0] PRBS_TAPS = 32'h8020_0003;
  localparam logic [DATA_W-1:0] PRBS_SEED = 32'hFFFF_FFFF;

  // ----------------------------------------------------------
  // Bundles
  // ----------------------------------------------------------
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } stream_t;

  // Word counts, error count and running cycles
  typedef struct packed {
    logic [COUNT_W-1:0] tx;
    logic [COUNT_W-1:0] rx;
    logic [COUNT_W-1:0] error;
    logic [COUNT_W-1:0] cycle;
  } bist_counts_t;

endpackage

`default_nettype wire

//--- design/bist_prbs_gen.sv
`timescale 1ns/1ns
`default_nettype none

module bist_prbs_gen (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             init,
  input  logic                             advance,
  output logic [bist_data_pkg::DATA_W-1:0] word
);

  import bist_data_pkg::*;

  logic [DATA_W-1:0] lfsr;
  logic [DATA_W-1:0] lfsr_next;

  // Galois step, taps folded in when the LSB shifts out
  assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ PRBS_TAPS) : (lfsr >> 1);

  // Current word is offered until consumed
  assign word = lfsr;

  always_ff @(posedge clk) begin
    if (rst || init) begin
      lfsr <= PRBS_SEED;
    end else if (advance) begin
      lfsr <= lfsr_next;
    end
  end

endmodule

`default_nettype wire

//--- design/bist_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module bist_fifo (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             wr,
  input  logic [bist_data_pkg::DATA_W-1:0] wr_data,
  input  logic                             rd,
  output bist_data_pkg::stream_t           rd_out,
  output logic                             full
);

  import bist_data_pkg::*;

  logic [DATA_W-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_PTR_W:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign full  = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
  assign do_wr = wr && !full;
  assign do_rd = rd && rd_out.valid;

  // Head of the queue shows without a read request
  assign rd_out = '{valid: count != '0, data: mem[rd_ptr]};

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Occupancy holds on simultaneous push and pop
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/bist_regs.sv
`timescale 1ns/1ns
`default_nettype none

module bist_regs (
  input  logic                             clk,
  input  logic                             rst,
  input  bist_reg_pkg::ctrl_req_t          ctrl_req,
  output bist_reg_pkg::ctrl_resp_t         ctrl_resp,
  input  bist_data_pkg::bist_counts_t      counts,
  input  logic                             running,
  output bist_reg_pkg::bist_cmd_t          cmd,
  output logic [bist_data_pkg::COUNT_W-1:0] num_words
);

  import bist_reg_pkg::*;
  import bist_data_pkg::*;

  // Zero-extend a count to 64 bits
  function automatic logic [63:0] widen(input logic [COUNT_W-1:0] value);
    return {{(64 - COUNT_W){1'b0}}, value};
  endfunction

  logic [CTRL_ADDR_W-1:0] word_addr;
  logic [COUNT_W-1:0]     num_bytes;
  logic [63:0]            num_bytes_w;
  logic [63:0]            tx_bytes;
  logic [63:0]            rx_bytes;
  logic [63:0]            err_w;
  logic [63:0]            cyc_w;
  logic                   rd_hit;
  logic                   wr_hit;
  logic [CTRL_DATA_W-1:0] rd_data;
  logic                   resp_ack;
  logic [CTRL_DATA_W-1:0] resp_data;

  // High-half snapshots, taken on the low-half read
  logic [31:0] tx_hi;
  logic [31:0] rx_hi;
  logic [31:0] err_hi;
  logic [31:0] cyc_hi;

  // Byte offset bits are don't-care
  assign word_addr = {ctrl_req.addr[CTRL_ADDR_W-1:2], 2'b00};

  // Words to bytes and back
  assign num_bytes_w = widen(num_bytes);
  assign tx_bytes    = widen(counts.tx) << BYTE_SHIFT;
  assign rx_bytes    = widen(counts.rx) << BYTE_SHIFT;
  assign err_w       = widen(counts.error);
  assign cyc_w       = widen(counts.cycle);
  assign num_words   = num_bytes >> BYTE_SHIFT;

  assign ctrl_resp = '{ack: resp_ack, data: resp_data};

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    rd_hit  = 1'b1;
    rd_data = '0;
    case (word_addr)
      REG_BIST_CTRL: begin
        rd_data[REG_BIST_RUNNING_POS] = running;
        rd_data[REG_BIST_CONT_POS]    = cmd.continuous;
      end
      REG_BIST_CLK_RATE:         rd_data = CLK_RATE;
      REG_BIST_NUM_BYTES_LO:     rd_data = num_bytes_w[31:0];
      REG_BIST_NUM_BYTES_HI:     rd_data = num_bytes_w[63:32];
      REG_BIST_TX_BYTE_COUNT_LO: rd_data = tx_bytes[31:0];
      REG_BIST_TX_BYTE_COUNT_HI: rd_data = tx_hi;
      REG_BIST_RX_BYTE_COUNT_LO: rd_data = rx_bytes[31:0];
      REG_BIST_RX_BYTE_COUNT_HI: rd_data = rx_hi;
      REG_BIST_ERROR_COUNT_LO:   rd_data = err_w[31:0];
      REG_BIST_ERROR_COUNT_HI:   rd_data = err_hi;
      REG_BIST_CYCLE_COUNT_LO:   rd_data = cyc_w[31:0];
      REG_BIST_CYCLE_COUNT_HI:   rd_data = cyc_hi;
      default:                   rd_hit  = 1'b0;
    endcase
  end

  // Only three registers take writes
  assign wr_hit = (word_addr == REG_BIST_CTRL) ||
                  (word_addr == REG_BIST_NUM_BYTES_LO) ||
                  (word_addr == REG_BIST_NUM_BYTES_HI);

  // ----------------------------------------------------------
  // Ack, command pulses and length
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_ack  <= 1'b0;
      cmd       <= '0;
      num_bytes <= '0;
    end else begin
      resp_ack   <= (ctrl_req.rd && rd_hit) || (ctrl_req.wr && wr_hit);
      // Pulses last one cycle
      cmd.start  <= 1'b0;
      cmd.stop   <= 1'b0;
      cmd.clear  <= 1'b0;
      cmd.inject <= 1'b0;
      if (ctrl_req.wr) begin
        case (word_addr)
          REG_BIST_CTRL: begin
            cmd.start      <= ctrl_req.data[REG_BIST_START_POS];
            cmd.stop       <= ctrl_req.data[REG_BIST_STOP_POS];
            cmd.clear      <= ctrl_req.data[REG_BIST_CLEAR_POS];
            cmd.inject     <= ctrl_req.data[REG_BIST_INJECT_POS];
            cmd.continuous <= ctrl_req.data[REG_BIST_CONT_POS];
          end
          // Byte offset bits stay at zero
          REG_BIST_NUM_BYTES_LO:
            num_bytes[31:BYTE_SHIFT] <= ctrl_req.data[31:BYTE_SHIFT];
          REG_BIST_NUM_BYTES_HI:
            num_bytes[COUNT_W-1:32] <= ctrl_req.data[COUNT_W-33:0];
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------------------------
  // Read data and snapshots
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (ctrl_req.rd && rd_hit) begin
      resp_data <= rd_data;
    end
    if (ctrl_req.rd) begin
      case (word_addr)
        REG_BIST_TX_BYTE_COUNT_LO: tx_hi  <= tx_bytes[63:32];
        REG_BIST_RX_BYTE_COUNT_LO: rx_hi  <= rx_bytes[63:32];
        REG_BIST_ERROR_COUNT_LO:   err_hi <= err_w[63:32];
        REG_BIST_CYCLE_COUNT_LO:   cyc_hi <= cyc_w[63:32];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/bist_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module bist_sequencer (
  input  logic                    clk,
  input  logic                    rst,
  input  bist_reg_pkg::bist_cmd_t cmd,
  input  logic                    tx_done,
  input  logic                    drained,
  input  logic                    fifo_full,
  output logic                    running,
  output logic                    gen_en,
  output logic                    fifo_wr,
  output logic                    inject_bit,
  output logic                    prbs_init
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN,
    ST_DONE
  } seq_state_t;

  seq_state_t state;
  logic       start_ok;
  logic       inject_pend;

  // Run and drain both count as running
  assign running = (state == ST_RUN) || (state == ST_DRAIN);

  // Start while running is dropped
  assign start_ok  = cmd.start && !running;
  assign prbs_init = start_ok || cmd.clear;

  // Continuous mode ignores the length
  assign gen_en     = (state == ST_RUN) && (cmd.continuous || !tx_done);
  assign fifo_wr    = gen_en && !fifo_full;
  assign inject_bit = inject_pend;

  // ----------------------------------------------------------
  // Test state
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE, ST_DONE: begin
          if (start_ok) begin
            state <= ST_RUN;
          end
        end
        ST_RUN: begin
          // Length reached, or host asked to stop
          if (cmd.stop || (tx_done && !cmd.continuous)) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Wait for the FIFO to empty
          if (drained) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------
  // Error injection request
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || prbs_init) begin
      inject_pend <= 1'b0;
    end else if (cmd.inject && (state == ST_RUN)) begin
      inject_pend <= 1'b1;
    end else if (fifo_wr) begin
      // Consumed by the corrupted word
      inject_pend <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/bist_stats.sv
`timescale 1ns/1ns
`default_nettype none

module bist_stats (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              prbs_init,
  input  logic                              running,
  input  logic                              fifo_wr,
  input  bist_data_pkg::stream_t            rx,
  input  logic [bist_data_pkg::DATA_W-1:0]  expected,
  input  logic [bist_data_pkg::COUNT_W-1:0] num_words,
  output bist_data_pkg::bist_counts_t       counts,
  output logic                              tx_done,
  output logic                              drained,
  output logic                              rx_pop
);

  logic mismatch;

  // Reader never stalls
  assign rx_pop = rx.valid;

  // Popped word against the predicted one
  assign mismatch = rx_pop && (rx.data != expected);

  // Length reached
  assign tx_done = counts.tx >= num_words;

  // Everything written has come back
  assign drained = counts.rx == counts.tx;

  // ----------------------------------------------------------
  // Counters
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || prbs_init) begin
      counts <= '0;
    end else begin
      if (fifo_wr) begin
        counts.tx <= counts.tx + 1'b1;
      end
      if (rx_pop) begin
        counts.rx <= counts.rx + 1'b1;
      end
      if (mismatch) begin
        counts.error <= counts.error + 1'b1;
      end
      // Every cycle of run and drain
      if (running) begin
        counts.cycle <= counts.cycle + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/ram_fifo_bist_top.sv
`timescale 1ns/1ns
`default_nettype none

module ram_fifo_bist_top (
  input  logic                     clk,
  input  logic                     rst,
  input  bist_reg_pkg::ctrl_req_t  ctrl_req,
  output bist_reg_pkg::ctrl_resp_t ctrl_resp
);

  import bist_reg_pkg::*;
  import bist_data_pkg::*;

  bist_cmd_t          cmd;
  bist_counts_t       counts;
  stream_t            rx;
  logic [COUNT_W-1:0] num_words;
  logic [DATA_W-1:0]  tx_word;
  logic [DATA_W-1:0]  tx_data;
  logic [DATA_W-1:0]  rx_expected;
  logic               running;
  // Generator enable, visible alongside fifo_wr for the checker
  logic               gen_en;
  logic               fifo_wr;
  logic               fifo_full;
  logic               inject_bit;
  logic               prbs_init;
  logic               tx_done;
  logic               drained;
  logic               rx_pop;

  // Injected error flips bit 0 of the outgoing word
  assign tx_data = {tx_word[DATA_W-1:1], tx_word[0] ^ inject_bit};

  bist_regs regs0 (
    .clk       (clk),
    .rst       (rst),
    .ctrl_req  (ctrl_req),
    .ctrl_resp (ctrl_resp),
    .counts    (counts),
    .running   (running),
    .cmd       (cmd),
    .num_words (num_words)
  );

  bist_sequencer seq0 (
    .clk        (clk),
    .rst        (rst),
    .cmd        (cmd),
    .tx_done    (tx_done),
    .drained    (drained),
    .fifo_full  (fifo_full),
    .running    (running),
    .gen_en     (gen_en),
    .fifo_wr    (fifo_wr),
    .inject_bit (inject_bit),
    .prbs_init  (prbs_init)
  );

  bist_stats stats0 (
    .clk       (clk),
    .rst       (rst),
    .prbs_init (prbs_init),
    .running   (running),
    .fifo_wr   (fifo_wr),
    .rx        (rx),
    .expected  (rx_expected),
    .num_words (num_words),
    .counts    (counts),
    .tx_done   (tx_done),
    .drained   (drained),
    .rx_pop    (rx_pop)
  );

  // Transmit source, steps on every FIFO write
  bist_prbs_gen tx_gen (
    .clk     (clk),
    .rst     (rst),
    .init    (prbs_init),
    .advance (fifo_wr),
    .word    (tx_word)
  );

  // Receive predictor, steps on every pop
  bist_prbs_gen rx_gen (
    .clk     (clk),
    .rst     (rst),
    .init    (prbs_init),
    .advance (rx_pop),
    .word    (rx_expected)
  );

  bist_fifo fifo0 (
    .clk     (clk),
    .rst     (rst),
    .wr      (fifo_wr),
    .wr_data (tx_data),
    .rd      (rx_pop),
    .rd_out  (rx),
    .full    (fifo_full)
  );

endmodule

`default_nettype wire

//--- dv/ram_fifo_bist_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ram_fifo_bist_checker (
  input logic                               clk,
  input logic                               rst,
  input logic                               ack,
  input logic                               req_rd,
  input logic                               req_wr,
  input logic                               gen_en,
  input logic                               fifo_wr,
  input logic [bist_data_pkg::FIFO_PTR_W:0] fifo_count,
  input logic                               running
);

  import bist_data_pkg::*;

  // ----------------------------------------------------------
  // Register port protocol
  // ----------------------------------------------------------
  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
    else $error("ctrl_resp.ack high two cycles in a row");

  // Host never reads and writes at once
  rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst) !(req_rd && req_wr))
    else $error("ctrl_req.rd and ctrl_req.wr high together");

  // ----------------------------------------------------------
  // FIFO and sequencer
  // ----------------------------------------------------------
  // Write only into a free slot, judged by the FIFO occupancy itself
  no_write_when_full: assert property (@(posedge clk) disable iff (rst)
    fifo_wr |-> (fifo_count < FIFO_DEPTH))
    else $error("FIFO write while full");

  // Generator stalls only when every slot is taken
  stall_only_when_full: assert property (@(posedge clk) disable iff (rst)
    (gen_en && (fifo_count < FIFO_DEPTH)) |-> fifo_wr)
    else $error("generator stalled with room left in the FIFO");

  // Reset leaves the test idle
  idle_after_reset: assert property (@(posedge clk) rst |=> !running)
    else $error("running high after reset");

endmodule

bind ram_fifo_bist_top ram_fifo_bist_checker chk0 (
  .clk        (clk),
  .rst        (rst),
  .ack        (ctrl_resp.ack),
  .req_rd     (ctrl_req.rd),
  .req_wr     (ctrl_req.wr),
  .gen_en     (gen_en),
  .fifo_wr    (fifo_wr),
  .fifo_count (fifo0.count),
  .running    (running)
);

`default_nettype wire

//--- dv/tb_ram_fifo_bist.sv
`timescale 1ns/1ns
`default_nettype none

module tb_ram_fifo_bist;

  import bist_reg_pkg::*;

  localparam int          CLK_PERIOD   = 100;
  localparam int          RESET_CYCLES = 5;
  // Watchdog budget per requested word and per command
  localparam int          WORD_CYCLES  = 4;
  localparam int          CMD_CYCLES   = 200;
  localparam logic [31:0] RAND_SEED    = 32'h0a86_e884;

  logic       clk;
  logic       rst;
  ctrl_req_t  ctrl_req;
  ctrl_resp_t ctrl_resp;

  // Parsed stimulus, one entry per command
  logic [7:0]   op_q[$];
  logic [31:0]  a_q[$];
  logic [31:0]  b_q[$];
  logic [255:0] name_q[$];

  logic [255:0] test_name;
  int           limit_cycles;
  bit           limit_ready;
  bit           in_test;
  int           errors;
  int           checks;
  int           test_errors;
  int           tests_run;
  int           tests_failed;

  ram_fifo_bist_top dut0 (
    .clk       (clk),
    .rst       (rst),
    .ctrl_req  (ctrl_req),
    .ctrl_resp (ctrl_resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------------------------
  // Stimulus file
  // ----------------------------------------------------------
  task automatic load_stimulus(output bit ok);
    int            fd;
    int            r;
    logic [7:0]    op;
    logic [31:0]   a;
    logic [31:0]   b;
    logic [255:0]  name;
    logic [1023:0] rest;
    ok = 1'b0;
    fd = $fopen("dv/bist_stimulus.txt", "r");
    if (fd != 0) begin
      while (1) begin
        r = $fscanf(fd, "%s", op);
        if (r != 1) break;
        a    = '0;
        b    = '0;
        name = '0;
        case (op)
          // Comment line, rest is skipped
          "#": r = $fgets(rest, fd);
          "T": r = $fscanf(fd, "%s", name);
          "N", "I": r = $fscanf(fd, "%h", a);
          "W", "R", "G", "M": r = $fscanf(fd, "%h %h", a, b);
          default: ;
        endcase
        if (op != "#") begin
          op_q.push_back(op);
          a_q.push_back(a);
          b_q.push_back(b);
          name_q.push_back(name);
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  // Words requested by length writes, plus slack per command and idle waits
  function automatic int watchdog_cycles();
    int total;
    total = RESET_CYCLES;
    foreach (op_q[i]) begin
      total += CMD_CYCLES;
      if (op_q[i] == "W" && a_q[i] == {12'h0, REG_BIST_NUM_BYTES_LO}) begin
        total += int'(b_q[i] / 4) * WORD_CYCLES;
      end
      if (op_q[i] == "I") begin
        total += int'(a_q[i]);
      end
    end
    return total;
  endfunction

  // ----------------------------------------------------------
  // Checks and reporting
  // ----------------------------------------------------------
  task automatic note_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    assert (got === exp) else begin
      $display("Error: time %0t %s expected 0x%0h got 0x%0h", $time, what, exp, got);
      note_error();
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("Error: time %0t %s", $time, msg);
      note_error();
    end
  endtask

  // Closes the running test, if any
  task automatic finish_test();
    if (in_test) begin
      tests_run++;
      if (test_errors == 0) begin
        $display("Test %0s: PASS", test_name);
      end else begin
        tests_failed++;
        $display("Test %0s: FAIL (%0d errors)", test_name, test_errors);
      end
    end
  endtask

  // ----------------------------------------------------------
  // Register transactions
  // ----------------------------------------------------------
  // Random 1 to 4 idle cycles
  task automatic idle_gap();
    int gap;
    gap = int'($urandom % 4) + 1;
    repeat (gap) @(negedge clk);
  endtask

  // Called on a falling edge, response sampled one cycle later
  task automatic access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                        output logic ack, output logic [31:0] rdata);
    ctrl_req.wr   = wr;
    ctrl_req.rd   = !wr;
    ctrl_req.addr = addr[CTRL_ADDR_W-1:0];
    ctrl_req.data = wdata;
    @(negedge clk);
    ack      = ctrl_resp.ack;
    rdata    = ctrl_resp.data;
    ctrl_req = '0;
    idle_gap();
  endtask

  // Low half first, which latches the high half
  task automatic read_wide(input logic [31:0] addr, output logic [63:0] value);
    logic        ack_lo;
    logic        ack_hi;
    logic [31:0] lo;
    logic [31:0] hi;
    access(1'b0, addr, '0, ack_lo, lo);
    access(1'b0, addr + 32'h4, '0, ack_hi, hi);
    check_true(ack_lo && ack_hi, $sformatf("no ack reading 64-bit value at 0x%02h", addr));
    value = {hi, lo};
  endtask

  task automatic poll_idle();
    logic        ack;
    logic [31:0] data;
    data = 32'hFFFF_FFFF;
    while (data[REG_BIST_RUNNING_POS]) begin
      access(1'b0, {12'h0, REG_BIST_CTRL}, '0, ack, data);
      check_true(ack, "no ack while polling CTRL");
      if (!ack) data = '0;
    end
  endtask

  task automatic run_command(input int i);
    logic        ack;
    logic [31:0] data;
    logic [63:0] first;
    logic [63:0] second;
    case (op_q[i])
      "T": begin
        finish_test();
        test_name   = name_q[i];
        test_errors = 0;
        in_test     = 1'b1;
      end
      "W": begin
        access(1'b1, a_q[i], b_q[i], ack, data);
        check_true(ack, $sformatf("no ack for write to 0x%02h", a_q[i]));
      end
      "R": begin
        access(1'b0, a_q[i], '0, ack, data);
        check_true(ack, $sformatf("no ack for read of 0x%02h", a_q[i]));
        if (ack) begin
          check_value($sformatf("ctrl_resp.data[0x%02h]", a_q[i]), {32'h0, b_q[i]},
                      {32'h0, data});
        end
      end
      "N": begin
        access(1'b0, a_q[i], '0, ack, data);
        check_true(!ack, $sformatf("unexpected ack for unmapped address 0x%02h", a_q[i]));
      end
      "P": poll_idle();
      "I": repeat (a_q[i]) @(negedge clk);
      "G": begin
        read_wide(a_q[i], first);
        check_true(first >= {32'h0, b_q[i]},
                   $sformatf("count at 0x%02h is %0d, below %0d", a_q[i], first, b_q[i]));
      end
      "M": begin
        read_wide(a_q[i], first);
        read_wide(b_q[i], second);
        check_value($sformatf("count at 0x%02h", b_q[i]), first, second);
        check_true(first != 0 && first[1:0] == 2'b00,
                   $sformatf("byte count %0d is zero or not a multiple of 4", first));
      end
      default: check_true(1'b0, "unknown command in stimulus file");
    endcase
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    bit ok;
    clk          = 1'b0;
    rst          = 1'b1;
    ctrl_req     = '0;
    errors       = 0;
    checks       = 0;
    test_errors  = 0;
    tests_run    = 0;
    tests_failed = 0;
    in_test      = 1'b0;
    void'($urandom(RAND_SEED));
    load_stimulus(ok);
    limit_cycles = watchdog_cycles();
    limit_ready  = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_true(ok, "stimulus file dv/bist_stimulus.txt could not be opened");
    foreach (op_q[i]) begin
      run_command(i);
    end
    finish_test();
    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Ends a run that stops making progress
  initial begin : watchdog
    wait (limit_ready);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog: run exceeded %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/bist_stimulus.txt
# columns: op arg1 arg2, numbers hex; T name, W addr data, R addr expect, N addr (no ack)
# P polls CTRL until idle, I cycles idles, G addr min (64-bit), M addr addr (64-bit equal)
T register_access
R 04 00989680
W 08 00000103
R 08 00000100
W 0c 0000015a
R 0c 0000005a
W 0c 00000000
N 40
N 33
T normal_run
W 08 00000190
W 00 00000001
P
R 10 00000190
R 14 00000000
R 18 00000190
R 1c 00000000
R 20 00000000
R 24 00000000
G 28 00000064
T error_injection
W 08 00000320
W 00 00000001
W 00 00000020
W 00 00000020
W 00 00000020
P
R 10 00000320
R 18 00000320
R 20 00000003
T continuous_stop
W 00 00000009
I 12c
R 00 00000018
W 00 00000002
P
M 10 18
R 20 00000000
T clear_rerun
W 00 00000004
R 10 00000000
R 18 00000000
R 20 00000000
R 28 00000000
R 2c 00000000
W 08 00000190
W 00 00000001
P
R 10 00000190
R 18 00000190
R 20 00000000
G 28 00000064

//--- tb.f
design/bist_reg_pkg.sv
design/bist_data_pkg.sv
design/bist_prbs_gen.sv
design/bist_fifo.sv
design/bist_regs.sv
design/bist_sequencer.sv
design/bist_stats.sv
design/ram_fifo_bist_top.sv
dv/ram_fifo_bist_checker.sv
dv/tb_ram_fifo_bist.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ram_fifo_bist -f tb.f

./obj_dir/Vtb_ram_fifo_bist | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
